//--- vexp_cfg.svh
`ifndef VEXP_CFG_SVH
`define VEXP_CFG_SVH

// vector width and lane latency in cycles
`define VEXP_LANES 4
`define VEXP_DEPTH 5

// fp16 exponent bias
`define FP16_BIAS 15

// fp16 constants with truncated mantissas
`define FP16_ONE   16'h3C00 // 1.0
`define FP16_HALF  16'h3800 // 0.5
`define FP16_SIXTH 16'h3155 // 1/6
`define FP16_LOG2E 16'h3DC5 // log2(e)
`define FP16_LN2   16'h398B // ln(2)

// biased exponent of 8.0
`define VEXP_X_LIMIT_EXP 18

`endif

//--- vexp_pkg.sv
`include "vexp_cfg.svh"

package vexp_pkg;

    // half-precision field split
    typedef struct packed {
        logic       sign;
        logic [4:0] exponent;
        logic [9:0] mantissa;
    } fp16_t;

    // one operand vector per strobe
    typedef struct packed {
        logic                    valid;
        fp16_t [`VEXP_LANES-1:0] x;
    } vexp_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`VEXP_LANES-1:0]  range_err; // per lane, set for |x| >= 8
        fp16_t [`VEXP_LANES-1:0] y;
    } vexp_rsp_t;

endpackage

//--- fp16_addsub.sv
`timescale 1ns/10ps

module fp16_addsub import vexp_pkg::*; (
    input  fp16_t a,
    input  fp16_t b,
    input  logic  sub,
    output fp16_t y
);

    fp16_t             bx;         // b with sub folded into its sign
    fp16_t             big;
    fp16_t             small_op;
    logic              eff_sub;
    logic [4:0]        ediff;
    logic [13:0]       sig_big;    // hidden one, 10 mantissa bits, 3 guard bits
    logic [13:0]       sig_sm_raw;
    logic [13:0]       sig_small;
    logic [27:0]       align;
    logic [14:0]       sum;
    logic [3:0]        lead;
    logic [14:0]       norm;
    logic signed [6:0] exp_res;

    always_comb begin
        bx      = b;
        bx.sign = b.sign ^ sub;

        // larger magnitude first so the difference never goes negative
        if ({bx.exponent, bx.mantissa} > {a.exponent, a.mantissa}) begin
            big      = bx;
            small_op = a;
        end else begin
            big      = a;
            small_op = bx;
        end
        eff_sub = big.sign ^ small_op.sign;
        ediff   = big.exponent - small_op.exponent;

        // subnormal inputs read as zero
        sig_big    = (big.exponent == '0) ? '0 : {1'b1, big.mantissa, 3'b000};
        sig_sm_raw = (small_op.exponent == '0) ? '0 : {1'b1, small_op.mantissa, 3'b000};

        align     = {sig_sm_raw, 14'b0} >> ediff;
        sig_small = align[27:14] | {13'b0, |align[13:0]}; // sticky bit

        sum = eff_sub ? ({1'b0, sig_big} - {1'b0, sig_small})
                      : ({1'b0, sig_big} + {1'b0, sig_small});

        // position of the leading one
        lead = '0;
        for (int i = 0; i < 15; i++) begin
            if (sum[i]) begin
                lead = 4'(i);
            end
        end

        if (lead == 4'd14) begin
            norm = sum >> 1; // carry out of the add
        end else begin
            norm = sum << (4'd13 - lead);
        end
        exp_res = $signed({2'b00, big.exponent}) + $signed({3'b000, lead}) - 7'sd13;

        // dropping norm[2:0] truncates toward zero
        if (sum == '0 || exp_res <= 0) begin
            y = '0;
        end else if (exp_res >= 31) begin
            y = '{sign: big.sign, exponent: 5'd30, mantissa: 10'h3ff}; // saturate
        end else begin
            y = '{sign: big.sign, exponent: exp_res[4:0], mantissa: norm[12:3]};
        end
    end

endmodule

//--- fp16_mul.sv
`timescale 1ns/10ps
`include "vexp_cfg.svh"

module fp16_mul import vexp_pkg::*; (
    input  fp16_t a,
    input  fp16_t b,
    output fp16_t y
);

    logic              sign;
    logic              zero_in;
    logic [21:0]       prod;       // 1.m x 1.m, in [1,4)
    logic [9:0]        mant;
    logic signed [6:0] exp_res;

    always_comb begin
        sign    = a.sign ^ b.sign;
        zero_in = (a.exponent == '0) || (b.exponent == '0); // subnormals count as zero
        prod    = {1'b1, a.mantissa} * {1'b1, b.mantissa};
        exp_res = $signed({2'b00, a.exponent}) + $signed({2'b00, b.exponent})
                  - $signed(7'(`FP16_BIAS));

        // at most one normalising shift
        if (prod[21]) begin
            mant    = prod[20:11];
            exp_res = exp_res + 7'sd1;
        end else begin
            mant = prod[19:10];
        end

        if (zero_in || exp_res <= 0) begin
            y = '{sign: sign, exponent: 5'd0, mantissa: 10'd0};
        end else if (exp_res >= 31) begin
            y = '{sign: sign, exponent: 5'd30, mantissa: 10'h3ff};
        end else begin
            y = '{sign: sign, exponent: exp_res[4:0], mantissa: mant};
        end
    end

    // inf and NaN are not handled by this datapath
    always_comb begin
        if (!$isunknown({a, b})) begin
            assert (a.exponent != 5'h1f && b.exponent != 5'h1f)
                else $error("fp16_mul: operand with all-ones exponent");
        end
    end

endmodule

//--- vexp.sv
`timescale 1ns/10ps
`include "vexp_cfg.svh"

module vexp import vexp_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  fp16_t x,
    output fp16_t y,
    output logic  range_err
);

    logic              rng_in;
    fp16_t             x_in;
    fp16_t             t_c;     // x * log2(e)
    fp16_t             s1_x;
    fp16_t             s1_t;
    logic              s1_rng;

    logic [10:0]       q_mag;
    logic signed [4:0] q_c;
    logic [2:0]        q_lead;
    fp16_t             q_fp;
    fp16_t             p_c;     // q * ln2
    fp16_t             r_c;
    fp16_t             s2_r;
    logic signed [4:0] s2_q;
    logic              s2_rng;

    fp16_t             r2_c;
    fp16_t             r1_c;
    fp16_t             s3_r;
    fp16_t             s3_r2;
    fp16_t             s3_1r;
    logic signed [4:0] s3_q;
    logic              s3_rng;

    fp16_t             r3_c;
    fp16_t             h_c;
    fp16_t             sum_c;
    fp16_t             s4_r3;
    fp16_t             s4_s;
    logic signed [4:0] s4_q;
    logic              s4_rng;

    fp16_t             c_c;
    fp16_t             e_c;     // taylor result before scaling
    logic signed [6:0] e_exp;
    fp16_t             y_c;

    // out-of-range lanes push zero through the datapath
    assign rng_in = (x.exponent >= 5'(`VEXP_X_LIMIT_EXP));
    assign x_in   = rng_in ? '0 : x;

    fp16_mul u_mul_log2e (.a(x_in), .b(`FP16_LOG2E), .y(t_c));

    always_comb begin
        // truncate t toward zero
        if (s1_t.exponent < 5'(`FP16_BIAS)) begin
            q_mag = '0;
        end else begin
            q_mag = {1'b1, s1_t.mantissa} >> (5'(`FP16_BIAS + 10) - s1_t.exponent);
        end
        q_c = s1_t.sign ? -5'(q_mag) : 5'(q_mag);

        // small integer back to fp16, always exact
        q_lead = '0;
        for (int i = 0; i < 5; i++) begin
            if (q_mag[i]) begin
                q_lead = 3'(i);
            end
        end
        q_fp.sign     = q_c[4];
        q_fp.exponent = (q_mag[4:0] == '0) ? 5'd0 : 5'(`FP16_BIAS) + 5'(q_lead);
        q_fp.mantissa = 10'({q_mag[4:0], 10'b0} >> q_lead);
    end

    fp16_mul    u_mul_qln2  (.a(q_fp),  .b(`FP16_LN2),  .y(p_c));
    fp16_addsub u_sub_r     (.a(s1_x),  .b(p_c),   .sub(1'b1), .y(r_c));

    fp16_mul    u_mul_sq    (.a(s2_r),  .b(s2_r),  .y(r2_c));
    fp16_addsub u_add_1r    (.a(`FP16_ONE), .b(s2_r), .sub(1'b0), .y(r1_c));

    fp16_mul    u_mul_cube  (.a(s3_r2), .b(s3_r),  .y(r3_c));
    fp16_mul    u_mul_half  (.a(s3_r2), .b(`FP16_HALF), .y(h_c));
    fp16_addsub u_add_sq    (.a(s3_1r), .b(h_c),   .sub(1'b0), .y(sum_c));

    fp16_mul    u_mul_sixth (.a(s4_r3), .b(`FP16_SIXTH), .y(c_c));
    fp16_addsub u_add_cube  (.a(s4_s),  .b(c_c),   .sub(1'b0), .y(e_c));

    // 2^q scaling on the exponent field
    always_comb begin
        e_exp = $signed({2'b00, e_c.exponent}) + 7'(s4_q);
        if (s4_rng || e_c.exponent == '0 || e_exp <= 0) begin
            y_c = '0;
        end else begin
            y_c = '{sign: e_c.sign, exponent: e_exp[4:0], mantissa: e_c.mantissa};
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            s1_x      <= '0;
            s1_t      <= '0;
            s1_rng    <= 1'b0;
            s2_r      <= '0;
            s2_q      <= '0;
            s2_rng    <= 1'b0;
            s3_r      <= '0;
            s3_r2     <= '0;
            s3_1r     <= '0;
            s3_q      <= '0;
            s3_rng    <= 1'b0;
            s4_r3     <= '0;
            s4_s      <= '0;
            s4_q      <= '0;
            s4_rng    <= 1'b0;
            y         <= '0;
            range_err <= 1'b0;
        end else begin
            s1_x      <= x_in;
            s1_t      <= t_c;
            s1_rng    <= rng_in;
            s2_r      <= r_c;
            s2_q      <= q_c;
            s2_rng    <= s1_rng;
            s3_r      <= s2_r;
            s3_r2     <= r2_c;
            s3_1r     <= r1_c;
            s3_q      <= s2_q;
            s3_rng    <= s2_rng;
            s4_r3     <= r3_c;
            s4_s      <= sum_c;
            s4_q      <= s3_q;
            s4_rng    <= s3_rng;
            y         <= y_c;            // output register
            range_err <= s4_rng;
        end
    end

    // |x| < 8 keeps q inside the scaling range
    assert property (@(posedge CLK) disable iff (!nRST)
        !s2_rng |-> (s2_q >= -12 && s2_q <= 11));

endmodule

//--- vexp_top.sv
`timescale 1ns/10ps
`include "vexp_cfg.svh"

module vexp_top import vexp_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  vexp_req_t req,
    output vexp_rsp_t rsp
);

    logic [`VEXP_DEPTH-1:0]  vld_sr;   // strobe delayed to match the lanes
    fp16_t [`VEXP_LANES-1:0] lane_y;
    logic [`VEXP_LANES-1:0]  lane_rng;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[`VEXP_DEPTH-2:0], req.valid};
        end
    end

    for (genvar i = 0; i < `VEXP_LANES; i++) begin : g_lane
        vexp u_lane (
            .CLK       (CLK),
            .nRST      (nRST),
            .x         (req.x[i]),
            .y         (lane_y[i]),
            .range_err (lane_rng[i])
        );
    end

    assign rsp = {vld_sr[`VEXP_DEPTH-1], lane_rng, lane_y};

    assert property (@(posedge CLK) disable iff (!nRST) !$isunknown(rsp.valid));

endmodule

//--- tb_vexp.sv
`timescale 1ns/10ps
`include "vexp_cfg.svh"

module tb_vexp import vexp_pkg::*; ();

    typedef struct packed {
        logic  rng;
        fp16_t y;
    } lane_out_t;

    typedef struct packed {
        int                      cyc;  // cycle the vector entered the DUT
        logic [`VEXP_LANES-1:0]  rng;
        fp16_t [`VEXP_LANES-1:0] y;
    } expect_t;

    typedef struct packed {
        vexp_req_t              req;
        logic [`VEXP_LANES-1:0] rng;   // range bits worked out by hand
    } row_t;

    localparam int n_rows = 11;

    // valid, x3, x2, x1, x0, range bits
    localparam row_t stim_table [n_rows] = '{
        {1'b1, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 4'b0000},
        {1'b1, 16'hB800, 16'h3800, 16'hBC00, 16'h3C00, 4'b0000}, // -0.5 0.5 -1 1
        {1'b1, 16'hC600, 16'hC400, 16'h4580, 16'h4200, 4'b0000}, // -6 -4 5.5 3
        {1'b1, 16'hC000, 16'h4A00, 16'h3C00, 16'h4800, 4'b0101}, // -2 12 1 8
        {1'b1, 16'hCA00, 16'h4780, 16'hC800, 16'h4000, 4'b1010}, // -12 7.5 -8 2
        {1'b0, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 4'b0000},
        {1'b1, 16'hBA00, 16'h4600, 16'h3400, 16'hC200, 4'b0000},
        {1'b0, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 4'b0000},
        {1'b0, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 4'b0000},
        {1'b1, 16'hC780, 16'h4400, 16'hBE00, 16'h3E00, 4'b0000},
        {1'b1, 16'h4800, 16'h4800, 16'h4800, 16'h4800, 4'b1111}
    };

    logic        CLK;
    logic        nRST;
    vexp_req_t   req;
    vexp_rsp_t   rsp;
    logic [15:0] lfsr;
    expect_t     pending [$];
    expect_t     head;
    int          wait_cnt;
    int          cycle_cnt = 0;
    int          checks = 0;
    int          mismatches = 0;
    int          failures = 0;
    logic        seen_rsp = 1'b0;

    vexp_top u_dut (.CLK(CLK), .nRST(nRST), .req(req), .rsp(rsp));

    always #5 CLK = ~CLK;

    // value in units of 2^-24, subnormals read as zero
    function automatic longint fixed_of(fp16_t a);
        longint v;
        if (a.exponent == 5'd0) begin
            return 0;
        end
        v = longint'({1'b1, a.mantissa}) << (a.exponent - 5'd1);
        return a.sign ? -v : v;
    endfunction

    function automatic real to_real(fp16_t a);
        return real'(fixed_of(a)) / 16777216.0;
    endfunction

    // mag * 2^e0 truncated to fp16
    function automatic fp16_t pack_fp(logic sign, longint unsigned mag, int e0, logic zero_sign);
        int              lead;
        int              ex;
        longint unsigned m;
        lead = -1;
        for (int i = 0; i < 64; i++) begin
            if (mag[i]) begin
                lead = i;
            end
        end
        ex = lead + e0 + 15;
        m  = (lead >= 10) ? (mag >> (lead - 10)) : (mag << (10 - lead));
        if (lead < 0 || ex <= 0) begin
            return {zero_sign, 15'b0};
        end
        if (ex >= 31) begin
            return {sign, 5'd30, 10'h3ff}; // largest finite
        end
        return {sign, ex[4:0], m[9:0]};
    endfunction

    function automatic fp16_t add_fp(fp16_t a, fp16_t b);
        longint s;
        s = fixed_of(a) + fixed_of(b); // exact sum, then truncate
        return pack_fp(s < 0, s < 0 ? -s : s, -24, 1'b0);
    endfunction

    function automatic fp16_t mul_fp(fp16_t a, fp16_t b);
        logic            sign;
        longint unsigned prod;
        sign = a.sign ^ b.sign;
        if (a.exponent == 5'd0 || b.exponent == 5'd0) begin
            return {sign, 15'b0};
        end
        prod = longint'({1'b1, a.mantissa}) * longint'({1'b1, b.mantissa});
        return pack_fp(sign, prod, int'(a.exponent) + int'(b.exponent) - 50, sign);
    endfunction

    // one lane, stage by stage
    function automatic lane_out_t lane_model(fp16_t x);
        lane_out_t o;
        fp16_t     xi;
        fp16_t     p;
        fp16_t     r;
        fp16_t     r2;
        fp16_t     s;
        fp16_t     e;
        longint    tf;
        int        q;
        int        ex;
        tf    = fixed_of(x);
        o.rng = (tf >= 64'sd134217728) || (tf <= -64'sd134217728); // |x| >= 8
        xi    = o.rng ? '0 : x;
        tf    = fixed_of(mul_fp(xi, `FP16_LOG2E));
        q     = int'((tf < 0 ? -tf : tf) >> 24);
        if (tf < 0) begin
            q = -q;
        end
        p      = mul_fp(pack_fp(q < 0, longint'(q < 0 ? -q : q), 0, 1'b0), `FP16_LN2);
        p.sign = ~p.sign;  // x - p
        r      = add_fp(xi, p);
        r2     = mul_fp(r, r);
        s      = add_fp(add_fp(`FP16_ONE, r), mul_fp(r2, `FP16_HALF));
        e      = add_fp(s, mul_fp(mul_fp(r2, r), `FP16_SIXTH));
        ex     = int'(e.exponent) + q;
        if (o.rng || e.exponent == 5'd0 || ex <= 0) begin
            o.y = '0;
        end else begin
            o.y = {e.sign, ex[4:0], e.mantissa};
        end
        return o;
    endfunction

    function automatic expect_t predict(vexp_req_t r, int cyc);
        expect_t   e;
        lane_out_t o;
        e.cyc = cyc;
        for (int l = 0; l < `VEXP_LANES; l++) begin
            o        = lane_model(r.x[l]);
            e.y[l]   = o.y;
            e.rng[l] = o.rng;
        end
        return e;
    endfunction

    function automatic logic [15:0] next_bits(int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16+x^14+x^13+x^11+1
            lfsr = {lfsr[14:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic vexp_req_t random_vector();
        vexp_req_t   r;
        logic [15:0] b;
        r.valid = 1'b1;
        for (int l = 0; l < `VEXP_LANES; l++) begin
            b = next_bits(1);
            r.x[l].sign = b[0];
            b = next_bits(5);
            // top lane may go out of range, the rest stay below 8
            r.x[l].exponent = (l == `VEXP_LANES - 1) ? b[4:0] : 5'(b % 18);
            b = next_bits(10);
            r.x[l].mantissa = b[9:0];
        end
        return r;
    endfunction

    function automatic bit near(fp16_t y, real target);
        real v;
        v = to_real(y);
        return (v > 0.98 * target) && (v < 1.02 * target);
    endfunction

    // model anchors and hand-worked range bits
    task automatic check_model();
        lane_out_t              o;
        logic [`VEXP_LANES-1:0] mask;
        o = lane_model(16'h0000);
        assert (o.y == 16'h3C00 && !o.rng) else begin
            $display("MISMATCH at %0t: model e^0 gives %h", $time, o.y);
            mismatches++;
        end
        o = lane_model(16'h3C00);
        assert (near(o.y, $exp(1.0))) else begin
            $display("MISMATCH at %0t: model e^1 gives %f", $time, to_real(o.y));
            mismatches++;
        end
        o = lane_model(16'hBC00);
        assert (near(o.y, $exp(-1.0))) else begin
            $display("MISMATCH at %0t: model e^-1 gives %f", $time, to_real(o.y));
            mismatches++;
        end
        for (int i = 0; i < n_rows; i++) begin
            for (int l = 0; l < `VEXP_LANES; l++) begin
                o       = lane_model(stim_table[i].req.x[l]);
                mask[l] = o.rng;
            end
            assert (mask == stim_table[i].rng) else begin
                $display("MISMATCH at %0t: row %0d range bits %b, expected %b",
                         $time, i, mask, stim_table[i].rng);
                mismatches++;
            end
        end
    endtask

    task automatic compare_rsp(expect_t e);
        checks++;
        assert (cycle_cnt - e.cyc == `VEXP_DEPTH) else begin
            $display("MISMATCH at %0t: latency %0d cycles, expected %0d",
                     $time, cycle_cnt - e.cyc, `VEXP_DEPTH);
            mismatches++;
        end
        for (int l = 0; l < `VEXP_LANES; l++) begin
            checks++;
            assert (rsp.y[l] === e.y[l] && rsp.range_err[l] === e.rng[l]) else begin
                $display("MISMATCH at %0t: lane %0d y=%h range_err=%b, expected y=%h range_err=%b",
                         $time, l, rsp.y[l], rsp.range_err[l], e.y[l], e.rng[l]);
                mismatches++;
            end
        end
    endtask

    // samples before this edge's updates land
    always @(posedge CLK) begin
        if (!nRST) begin
            if (cycle_cnt > 0) begin
                assert (rsp.valid === 1'b0 && rsp.range_err === '0) else begin
                    $display("reset state not clean at %0t: valid=%b range_err=%b",
                             $time, rsp.valid, rsp.range_err);
                    failures++;
                end
            end
        end else begin
            if (req.valid === 1'b1) begin
                pending.push_back(predict(req, cycle_cnt));
            end
            if (rsp.valid === 1'b1) begin
                seen_rsp = 1'b1;
                assert (pending.size() != 0) else begin
                    $display("response at %0t with no vector outstanding", $time);
                    failures++;
                end
                if (pending.size() != 0) begin
                    head = pending.pop_front();
                    compare_rsp(head);
                end
            end else if (!seen_rsp) begin
                assert (rsp.range_err === '0) else begin
                    $display("range_err set at %0t before any response", $time);
                    failures++;
                end
            end
        end
        cycle_cnt++;
    end

    initial begin
        CLK  = 1'b0;
        nRST = 1'b0;
        req  = '0;
        lfsr = 16'd51084;
        check_model();
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            req <= stim_table[i].req;  // first row goes in with reset release
            @(posedge CLK);
        end
        for (int n = 0; n < 200; n++) begin
            req <= random_vector();
            @(posedge CLK);
        end
        req <= '0;
        wait_cnt = 0;
        while (pending.size() != 0 && wait_cnt < 20) begin
            @(posedge CLK);
            wait_cnt++;
        end
        assert (pending.size() == 0) else begin
            $display("timeout: %0d vectors never came back", pending.size());
            failures++;
        end
        repeat (`VEXP_DEPTH + 2) @(posedge CLK); // catch stray responses
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
vexp_pkg.sv
fp16_addsub.sv
fp16_mul.sv
vexp.sv
vexp_top.sv
tb_vexp.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vexp
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
